// File: Makefile
SIM = obj_dir/Vtb_dcache

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): dcache.f $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)
	verilator --binary --timing --top-module tb_dcache -f dcache.f -o Vtb_dcache

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: dcache.f
+incdir+rtl
rtl/dcache_geom_pkg.sv
rtl/dcache_ctrl_pkg.sv
rtl/dcache_array_if.sv
rtl/dcache_store.sv
rtl/dcache_ctrl.sv
rtl/dcache.sv
tests/tb_dcache.sv

// File: rtl/dcache.sv
`timescale 1ns/1ps

module dcache
    import dcache_geom_pkg::*;
    import dcache_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    // CPU side
    input  logic       valid,
    input  logic       op,
    input  logic       uncache_en,
    input  xfer_type_t size,
    input  tag_t       tag,
    input  index_t     index,
    input  offset_t    offset,
    input  strb_t      wstrb,
    input  word_t      wdata,
    output logic       addr_ok,
    output logic       data_ok,
    output word_t      rdata,
    output logic       busy,
    // bus read channel
    output logic       rd_req,
    output xfer_type_t rd_type,
    output word_t      rd_addr,
    input  logic       rd_rdy,
    input  logic       ret_valid,
    input  logic       ret_last,
    input  word_t      ret_data,
    // bus write channel
    output logic       wr_req,
    output xfer_type_t wr_type,
    output word_t      wr_addr,
    output strb_t      wr_wstrb,
    output line_t      wr_data,
    input  logic       wr_rdy
);

    dcache_array_if arr ();

    // names match the controller's ports one to one
    dcache_ctrl u_ctrl (.*);

    dcache_store u_store (
        .clk    (clk),
        .resetn (resetn),
        .arr    (arr)
    );

endmodule

// File: rtl/dcache_array_if.sv
`timescale 1ns/1ps

interface dcache_array_if import dcache_geom_pkg::*; ();

    // request fields out of the controller's buffer
    index_t   req_index;
    tag_t     req_tag;
    offset_t  req_offset;
    strb_t    req_wstrb;
    word_t    req_wdata;

    // update strobes
    logic     refill_en;
    line_t    refill_line;
    logic     write_en;

    // lookup results, all for req_index
    way_sel_t hit_way;
    word_t    hit_word;
    way_sel_t victim_way;
    logic     victim_valid;
    logic     victim_dirty;
    tag_t     victim_tag;
    line_t    victim_line;

    modport ctrl (
        output req_index, req_tag, req_offset, req_wstrb, req_wdata,
        output refill_en, refill_line, write_en,
        input  hit_way, hit_word, victim_way, victim_valid, victim_dirty,
        input  victim_tag, victim_line
    );

    modport store (
        input  req_index, req_tag, req_offset, req_wstrb, req_wdata,
        input  refill_en, refill_line, write_en,
        output hit_way, hit_word, victim_way, victim_valid, victim_dirty,
        output victim_tag, victim_line
    );

endinterface

// File: rtl/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_ctrl
    import dcache_geom_pkg::*;
    import dcache_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         resetn,
    input  logic         valid,
    input  logic         op,
    input  logic         uncache_en,
    input  xfer_type_t   size,
    input  tag_t         tag,
    input  index_t       index,
    input  offset_t      offset,
    input  strb_t        wstrb,
    input  word_t        wdata,
    output logic         addr_ok,
    output logic         data_ok,
    output logic         busy,
    output word_t        rdata,
    output logic         rd_req,
    output xfer_type_t   rd_type,
    output word_t        rd_addr,
    input  logic         rd_rdy,
    input  logic         ret_valid,
    input  logic         ret_last,
    input  word_t        ret_data,
    output logic         wr_req,
    output xfer_type_t   wr_type,
    output word_t        wr_addr,
    output strb_t        wr_wstrb,
    output line_t        wr_data,
    input  logic         wr_rdy,
    dcache_array_if.ctrl arr
);

    main_state_t state;
    logic        req_op;
    logic        req_uncached;
    xfer_type_t  req_size;
    beat_t       beat;
    word_t       refill_buf [`DC_WORDS_PER_LINE];
    word_t       unc_rdata_q;
    logic        cache_hit;
    logic        last_beat;
    logic        capture;
    word_t       full_addr;

    // uncached accesses never hit, whatever the tags say
    assign cache_hit = (|arr.hit_way) && !req_uncached;
    assign last_beat = ret_valid && ret_last;
    assign capture   = (state == main_idle) && valid;
    assign full_addr = {arr.req_tag, arr.req_index, arr.req_offset};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state         <= main_idle;
            req_op        <= 1'b0;
            req_uncached  <= 1'b0;
            beat          <= '0;
            arr.refill_en <= 1'b0;
        end else begin
            arr.refill_en <= 1'b0;
            if (capture) begin
                req_op       <= op;
                req_uncached <= uncache_en;
            end
            case (state)
                main_idle: begin
                    if (valid) begin
                        state <= main_lookup;
                    end
                end
                main_lookup: begin
                    if (cache_hit) begin
                        state <= req_op ? main_write : main_idle;
                    end else if (req_uncached) begin
                        state <= req_op ? main_write_back : main_replace;
                    end else if (arr.victim_valid && arr.victim_dirty) begin
                        state <= main_write_back;
                    end else begin
                        state <= main_replace;
                    end
                end
                main_write_back: begin
                    if (wr_rdy) begin
                        state <= main_replace;
                    end
                end
                main_replace: begin
                    // uncached store is done once the write went out
                    if (req_uncached && req_op) begin
                        state <= main_idle;
                    end else if (rd_rdy) begin
                        state <= main_refill;
                        beat  <= '0;
                    end
                end
                main_refill: begin
                    if (ret_valid) begin
                        beat <= beat + 1'b1;
                    end
                    if (last_beat) begin
                        state         <= req_uncached ? main_idle : main_retry;
                        arr.refill_en <= !req_uncached;
                    end
                end
                main_retry: begin
                    // first cycle here still misses while the line is written
                    if (cache_hit) begin
                        state <= req_op ? main_write : main_idle;
                    end
                end
                main_write: begin
                    state <= main_idle;
                end
                default: begin
                    state <= main_idle;
                end
            endcase
        end
    end

    // request fields and refill data
    always_ff @(posedge clk) begin
        if (capture) begin
            arr.req_tag    <= tag;
            arr.req_index  <= index;
            arr.req_offset <= offset;
            arr.req_wstrb  <= wstrb;
            arr.req_wdata  <= wdata;
            req_size       <= size;
        end
        if (state == main_refill && ret_valid) begin
            refill_buf[beat] <= ret_data;
        end
        if (state == main_refill && last_beat && req_uncached) begin
            unc_rdata_q <= ret_data;
        end
    end

    // word 0 sits in the low bits
    always_comb begin
        for (int w = 0; w < `DC_WORDS_PER_LINE; w++) begin
            arr.refill_line[w*`DC_WORD_W +: `DC_WORD_W] = refill_buf[w];
        end
    end

    assign arr.write_en = (state == main_write);

    assign busy    = (state != main_idle);
    assign addr_ok = (state == main_lookup);

    always_comb begin
        if (req_uncached) begin
            data_ok = req_op ? (state == main_write_back && wr_rdy)
                             : (state == main_refill && last_beat);
            rdata   = (state == main_refill && last_beat) ? ret_data : unc_rdata_q;
        end else begin
            data_ok = (state == main_lookup || state == main_retry) && cache_hit;
            rdata   = arr.hit_word;
        end
    end

    // read channel, also used for uncached loads
    assign rd_req  = (state == main_replace) && !(req_uncached && req_op);
    assign rd_type = req_uncached ? req_size : `DC_TYPE_LINE;
    assign rd_addr = req_uncached ? full_addr : {arr.req_tag, arr.req_index, offset_t'(0)};

    // write channel carries either a victim line or one uncached word
    assign wr_req   = (state == main_write_back) && wr_rdy;
    assign wr_type  = req_uncached ? req_size : `DC_TYPE_LINE;
    assign wr_addr  = req_uncached ? full_addr
                                   : {arr.victim_tag, arr.req_index, offset_t'(0)};
    assign wr_wstrb = req_uncached ? arr.req_wstrb : '1;
    assign wr_data  = req_uncached ? {{(`DC_LINE_W-`DC_WORD_W){1'b0}}, arr.req_wdata}
                                   : arr.victim_line;

endmodule

// File: rtl/dcache_ctrl_pkg.sv
package dcache_ctrl_pkg;

    // main FSM of the controller
    typedef enum logic [2:0] {
        main_idle,
        main_lookup,
        main_write_back,
        main_replace,
        main_refill,
        main_retry,
        main_write
    } main_state_t;

    // size code for uncached, line code otherwise
    typedef logic [2:0] xfer_type_t;

endpackage

// File: rtl/dcache_geom_pkg.sv
`include "dcache_params.svh"

package dcache_geom_pkg;

    // address fields
    typedef logic [`DC_TAG_W-1:0]    tag_t;
    typedef logic [`DC_INDEX_W-1:0]  index_t;
    typedef logic [`DC_OFFSET_W-1:0] offset_t;

    // payload
    typedef logic [`DC_WORD_W-1:0]   word_t;
    typedef logic [`DC_LINE_W-1:0]   line_t;
    typedef logic [`DC_WORD_W/8-1:0] strb_t;

    // one bit per way
    typedef logic [`DC_WAYS-1:0]     way_sel_t;

    // counts refill beats within a line
    typedef logic [$clog2(`DC_WORDS_PER_LINE)-1:0] beat_t;

endpackage

// File: rtl/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// address split, 20 + 8 + 4
`define DC_TAG_W           20
`define DC_INDEX_W         8
`define DC_OFFSET_W        4

// data widths
`define DC_WORD_W          32
`define DC_LINE_W          128

// organisation
`define DC_WAYS            2
`define DC_WORDS_PER_LINE  4

// bus transfer type for a whole line
`define DC_TYPE_LINE       3'd4

`endif

// File: rtl/dcache_store.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_store import dcache_geom_pkg::*; (
    input logic          clk,
    input logic          resetn,
    dcache_array_if.store arr
);

    localparam int NUM_SETS = 1 << `DC_INDEX_W;

    tag_t  tag_arr  [`DC_WAYS][NUM_SETS];
    line_t data_arr [`DC_WAYS][NUM_SETS];

    // status bits per way, cleared at reset
    logic [NUM_SETS-1:0] valid_q [`DC_WAYS];
    logic [NUM_SETS-1:0] dirty_q [`DC_WAYS];

    line_t       hit_line;
    line_t       write_line;
    word_t       merged_word;
    logic [1:0]  word_sel;
    int unsigned victim_num;
    logic        victim_found;

    assign word_sel = arr.req_offset[`DC_OFFSET_W-1:2];

    // tag compare and hit line mux
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            arr.hit_way[w] = valid_q[w][arr.req_index] &&
                             (tag_arr[w][arr.req_index] == arr.req_tag);
            if (arr.hit_way[w]) begin
                hit_line = hit_line | data_arr[w][arr.req_index];
            end
        end
    end

    assign arr.hit_word = hit_line[word_sel*`DC_WORD_W +: `DC_WORD_W];

    // invalid way first, then clean way, else way 0
    always_comb begin
        victim_num   = 0;
        victim_found = 1'b0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (!victim_found && !valid_q[w][arr.req_index]) begin
                victim_num   = w;
                victim_found = 1'b1;
            end
        end
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (!victim_found && !dirty_q[w][arr.req_index]) begin
                victim_num   = w;
                victim_found = 1'b1;
            end
        end
        arr.victim_way             = '0;
        arr.victim_way[victim_num] = 1'b1;
    end

    assign arr.victim_valid = valid_q[victim_num][arr.req_index];
    assign arr.victim_dirty = dirty_q[victim_num][arr.req_index];
    assign arr.victim_tag   = tag_arr[victim_num][arr.req_index];
    assign arr.victim_line  = data_arr[victim_num][arr.req_index];

    // byte merge of the store data into the hit word
    always_comb begin
        for (int b = 0; b < `DC_WORD_W/8; b++) begin
            merged_word[b*8 +: 8] = arr.req_wstrb[b] ? arr.req_wdata[b*8 +: 8]
                                                     : arr.hit_word[b*8 +: 8];
        end
        write_line = hit_line;
        write_line[word_sel*`DC_WORD_W +: `DC_WORD_W] = merged_word;
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            if (arr.refill_en && arr.victim_way[w]) begin
                tag_arr[w][arr.req_index]  <= arr.req_tag;
                data_arr[w][arr.req_index] <= arr.refill_line;
            end
            if (arr.write_en && arr.hit_way[w]) begin
                data_arr[w][arr.req_index] <= write_line;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                // a refilled line starts clean
                if (arr.refill_en && arr.victim_way[w]) begin
                    valid_q[w][arr.req_index] <= 1'b1;
                    dirty_q[w][arr.req_index] <= 1'b0;
                end
                if (arr.write_en && arr.hit_way[w]) begin
                    dirty_q[w][arr.req_index] <= 1'b1;
                end
            end
        end
    end

endmodule

// File: tests/tb_dcache.sv
`timescale 1ns/1ps
`include "dcache_params.svh"

module tb_dcache
    import dcache_geom_pkg::*;
    import dcache_ctrl_pkg::*;
();

    localparam int TIMEOUT   = 200;
    localparam int MEM_WORDS = 65536;

    logic       clk = 1'b0;
    logic       resetn;
    logic       valid;
    logic       op;
    logic       uncache_en;
    xfer_type_t size;
    tag_t       tag;
    index_t     index;
    offset_t    offset;
    strb_t      wstrb;
    word_t      wdata;
    logic       addr_ok;
    logic       data_ok;
    logic       busy;
    word_t      rdata;
    logic       rd_req;
    xfer_type_t rd_type;
    word_t      rd_addr;
    logic       rd_rdy = 1'b0;
    logic       ret_valid = 1'b0;
    logic       ret_last = 1'b0;
    word_t      ret_data = '0;
    logic       wr_req;
    xfer_type_t wr_type;
    word_t      wr_addr;
    strb_t      wr_wstrb;
    line_t      wr_data;
    logic       wr_rdy = 1'b0;

    // memory model and bus records, owned by the responder
    word_t      mem [MEM_WORDS];
    int         seed = 78636;
    bit         mem_loaded = 1'b0;
    int         rd_wait;
    int         wr_wait;
    int         beats_left;
    word_t      beat_addr;
    int         rd_count = 0;
    int         wr_count = 0;
    word_t      last_rd_addr;
    xfer_type_t last_rd_type;
    word_t      last_wr_addr;
    xfer_type_t last_wr_type;
    strb_t      last_wr_wstrb;
    line_t      last_wr_data;

    string      cur_test;
    int         err_count = 0;
    int         test_errs;
    int         n_pass = 0;
    int         n_fail = 0;

    dcache UUT (.*);

    always #5 clk = ~clk;

    function automatic word_t make_addr(input tag_t t, input index_t i, input offset_t o);
        return {t, i, o};
    endfunction

    // bytes with their strobe set come from the new word
    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                          input strb_t st);
        word_t r;
        r = old_w;
        for (int b = 0; b < 4; b++) begin
            if (st[b]) begin
                r[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return r;
    endfunction

    // bus responder
    always @(posedge clk) begin
        if (!resetn) begin
            if (!mem_loaded) begin
                for (int i = 0; i < MEM_WORDS; i++) begin
                    mem[i] = $random(seed);
                end
                mem_loaded = 1'b1;
            end
            rd_rdy     <= 1'b0;
            wr_rdy     <= 1'b0;
            ret_valid  <= 1'b0;
            ret_last   <= 1'b0;
            beats_left = 0;
        end else begin
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            if (beats_left > 0) begin
                ret_valid  <= 1'b1;
                ret_last   <= (beats_left == 1);
                ret_data   <= mem[beat_addr[17:2]];
                beat_addr  = beat_addr + 32'd4;
                beats_left = beats_left - 1;
            end else if (rd_req && rd_rdy) begin
                rd_rdy       <= 1'b0;
                rd_count     = rd_count + 1;
                last_rd_addr = rd_addr;
                last_rd_type = rd_type;
                beat_addr    = rd_addr;
                beats_left   = (rd_type == `DC_TYPE_LINE) ? `DC_WORDS_PER_LINE : 1;
            end else if (rd_req) begin
                if (rd_wait == 0) begin
                    rd_rdy <= 1'b1;
                end else begin
                    rd_wait--;
                end
            end else begin
                rd_wait = $unsigned($random(seed)) % 4;
            end

            // write side, one transfer per wr_req cycle
            if (wr_req) begin
                wr_rdy        <= 1'b0;
                wr_count      = wr_count + 1;
                last_wr_addr  = wr_addr;
                last_wr_type  = wr_type;
                last_wr_wstrb = wr_wstrb;
                last_wr_data  = wr_data;
                if (wr_type == `DC_TYPE_LINE) begin
                    for (int w = 0; w < 4; w++) begin
                        mem[{wr_addr[17:4], 2'(w)}] = wr_data[w*32 +: 32];
                    end
                end else begin
                    mem[wr_addr[17:2]] = merge_bytes(mem[wr_addr[17:2]], wr_data[31:0],
                                                     wr_wstrb);
                end
                wr_wait = $unsigned($random(seed)) % 4;
            end else if (!busy) begin
                wr_rdy  <= 1'b0;
                wr_wait = $unsigned($random(seed)) % 4;
            end else if (wr_wait == 0) begin
                wr_rdy <= 1'b1;
            end else begin
                wr_wait--;
            end
        end
    end

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_addr(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_line(input string what, input line_t exp, input line_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_type(input string what, input xfer_type_t exp,
                              input xfer_type_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_strb(input string what, input strb_t exp, input strb_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %b, actual %b", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %b, actual %b", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("[FAIL] %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            err_count++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = err_count;
    endtask

    task automatic end_test();
        if (err_count == test_errs) begin
            $display("%s: passed", cur_test);
            n_pass++;
        end else begin
            $display("%s: failed", cur_test);
            n_fail++;
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            $display("%s: timed out waiting for the cache to go idle", cur_test);
            err_count++;
        end
    endtask

    // valid is high for one cycle, the DUT captures it at the next edge
    task automatic send_req(input logic wr, input logic unc, input xfer_type_t sz,
                            input word_t addr, input strb_t st, input word_t wd);
        wait_idle();
        @(posedge clk);
        valid      <= 1'b1;
        op         <= wr;
        uncache_en <= unc;
        size       <= sz;
        tag        <= addr[31:12];
        index      <= addr[11:4];
        offset     <= addr[3:0];
        wstrb      <= st;
        wdata      <= wd;
        @(posedge clk);
        valid <= 1'b0;
    endtask

    task automatic wait_data(output word_t data);
        int n;
        n = 0;
        @(negedge clk);
        while (!data_ok && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        data = rdata;
        if (!data_ok) begin
            $display("%s: timed out waiting for data_ok", cur_test);
            err_count++;
        end
    endtask

    task automatic test_read_miss();
        word_t addr;
        word_t got;
        int    rd_before;
        begin_test("read_miss");
        addr      = make_addr(20'h1, 8'h10, 4'h8);
        rd_before = rd_count;
        send_req(1'b0, 1'b0, 3'd2, addr, 4'h0, 32'h0);
        wait_data(got);
        check_word("rdata", mem[addr[17:2]], got);
        wait_idle();
        check_count("bus reads", rd_before + 1, rd_count);
        check_type("rd_type", `DC_TYPE_LINE, last_rd_type);
        check_addr("rd_addr", {addr[31:4], 4'h0}, last_rd_addr);
        end_test();
    endtask

    task automatic test_read_hit();
        word_t addr;
        int    rd_before;
        begin_test("read_hit");
        addr      = make_addr(20'h1, 8'h10, 4'hc);
        rd_before = rd_count;
        send_req(1'b0, 1'b0, 3'd2, addr, 4'h0, 32'h0);
        // lookup cycle right after the valid cycle
        @(negedge clk);
        check_flag("addr_ok in lookup", 1'b1, addr_ok);
        check_flag("busy in lookup", 1'b1, busy);
        if (!data_ok) begin
            $display("%s: data_ok did not come one cycle after valid", cur_test);
            err_count++;
        end else begin
            check_word("rdata", mem[addr[17:2]], rdata);
        end
        // a read hit is back in idle right after lookup
        @(negedge clk);
        check_flag("addr_ok after lookup", 1'b0, addr_ok);
        check_flag("busy after hit", 1'b0, busy);
        wait_idle();
        check_count("bus reads", rd_before, rd_count);
        end_test();
    endtask

    task automatic test_write_hit();
        word_t addr;
        word_t got;
        word_t expected;
        int    rd_before;
        int    wr_before;
        begin_test("write_hit");
        addr      = make_addr(20'h1, 8'h10, 4'h4);
        expected  = merge_bytes(mem[addr[17:2]], 32'ha5a5_5a5a, 4'b0101);
        rd_before = rd_count;
        wr_before = wr_count;
        send_req(1'b1, 1'b0, 3'd2, addr, 4'b0101, 32'ha5a5_5a5a);
        wait_data(got);
        send_req(1'b0, 1'b0, 3'd2, addr, 4'h0, 32'h0);
        wait_data(got);
        check_word("merged rdata", expected, got);
        wait_idle();
        check_count("bus reads", rd_before, rd_count);
        check_count("bus writes", wr_before, wr_count);
        end_test();
    endtask

    task automatic test_dirty_evict();
        word_t a_first;
        word_t a_second;
        word_t a_third;
        word_t merged;
        word_t exp_third;
        word_t got;
        line_t exp_line;
        int    wr_before;
        begin_test("dirty_evict");
        a_first  = make_addr(20'h2, 8'h20, 4'h0);
        a_second = make_addr(20'h3, 8'h20, 4'h4);
        a_third  = make_addr(20'h4, 8'h20, 4'h8);
        for (int w = 0; w < 4; w++) begin
            exp_line[w*32 +: 32] = mem[{a_first[17:4], 2'(w)}];
        end
        merged         = merge_bytes(mem[a_first[17:2]], 32'h1357_9bdf, 4'b1100);
        exp_line[31:0] = merged;
        exp_third      = mem[a_third[17:2]];
        // both ways end up dirty
        send_req(1'b1, 1'b0, 3'd2, a_first, 4'b1100, 32'h1357_9bdf);
        wait_data(got);
        send_req(1'b1, 1'b0, 3'd2, a_second, 4'b1111, 32'hcafe_f00d);
        wait_data(got);
        wr_before = wr_count;
        send_req(1'b0, 1'b0, 3'd2, a_third, 4'h0, 32'h0);
        wait_data(got);
        check_word("third tag rdata", exp_third, got);
        wait_idle();
        check_count("write-backs", wr_before + 1, wr_count);
        check_addr("wr_addr", {a_first[31:4], 4'h0}, last_wr_addr);
        check_type("wr_type", `DC_TYPE_LINE, last_wr_type);
        check_line("wr_data", exp_line, last_wr_data);
        // evicted line comes back from memory
        send_req(1'b0, 1'b0, 3'd2, a_first, 4'h0, 32'h0);
        wait_data(got);
        check_word("evicted rdata", merged, got);
        end_test();
    endtask

    task automatic test_uncached();
        word_t addr;
        word_t got;
        word_t expected;
        int    rd_before;
        begin_test("uncached");
        addr     = make_addr(20'h5, 8'h30, 4'h6);
        expected = merge_bytes(mem[addr[17:2]], 32'h1234_5678, 4'b1100);
        send_req(1'b1, 1'b1, 3'd1, addr, 4'b1100, 32'h1234_5678);
        wait_data(got);
        wait_idle();
        check_type("wr_type", 3'd1, last_wr_type);
        check_addr("wr_addr", addr, last_wr_addr);
        check_strb("wr_wstrb", 4'b1100, last_wr_wstrb);
        check_line("wr_data", {96'h0, 32'h1234_5678}, last_wr_data);
        // nothing allocated, so each read goes to the bus
        for (int k = 0; k < 2; k++) begin
            rd_before = rd_count;
            send_req(1'b0, 1'b1, 3'd1, addr, 4'h0, 32'h0);
            wait_data(got);
            check_word("uncached rdata", expected, got);
            @(negedge clk);
            check_word("held rdata", expected, rdata);
            wait_idle();
            check_count("bus reads", rd_before + 1, rd_count);
            check_type("rd_type", 3'd1, last_rd_type);
            check_addr("rd_addr", addr, last_rd_addr);
        end
        end_test();
    endtask

    initial begin
        resetn     <= 1'b0;
        valid      <= 1'b0;
        op         <= 1'b0;
        uncache_en <= 1'b0;
        size       <= '0;
        tag        <= '0;
        index      <= '0;
        offset     <= '0;
        wstrb      <= '0;
        wdata      <= '0;
        repeat (16) @(posedge clk);
        resetn <= 1'b1;

        test_read_miss();
        test_read_hit();
        test_write_hit();
        test_dirty_evict();
        test_uncached();

        $display("tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0 && err_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
